//--- verilog/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Width of the integer data path and of an instruction word
`define RV_XLEN 32

// Instruction memory depth in words
`define RV_IMEM_DEPTH 64

// Data memory depth in words
`define RV_DMEM_DEPTH 64

`endif

//--- verilog/rvIsaPkg.sv
`default_nettype none

`include "rv_settings.svh"

package rvIsaPkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [4:0]          regIdx_t;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        EQ,    // Compare ops give 0 or 1
        NE,
        LT,
        GE,
        LTU,
        GEU
    } aluOp_t;

endpackage

`default_nettype wire

//--- verilog/rvCorePkg.sv
`default_nettype none

package rvCorePkg;

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        EXECUTE,
        WRITEBACK
    } phase_t;

    typedef struct packed {
        rvIsaPkg::aluOp_t aluOp;
        logic             useImm;       // Operand B is imm
        logic             usePc;        // Operand A is pc
        logic             regWrite;
        logic             memRead;
        logic             memWrite;
        logic             isBranch;
        logic             isJump;
        logic             resultIsLink; // Write back pc+4
    } ctrl_t;

    typedef struct packed {
        rvIsaPkg::word_t pc;
        rvIsaPkg::word_t instr;
    } fetchOut_t;

    typedef struct packed {
        rvIsaPkg::word_t   pc;
        ctrl_t             ctrl;
        rvIsaPkg::word_t   rs1Val;
        rvIsaPkg::word_t   rs2Val;
        rvIsaPkg::word_t   imm;
        rvIsaPkg::regIdx_t rd;
    } decodeOut_t;

    typedef struct packed {
        rvIsaPkg::word_t   pc;
        ctrl_t             ctrl;
        rvIsaPkg::word_t   aluResult;
        rvIsaPkg::word_t   storeData;
        rvIsaPkg::regIdx_t rd;
        rvIsaPkg::word_t   nextPc;
    } execOut_t;

    typedef struct packed {
        rvIsaPkg::word_t   pc;
        logic              regWrite;
        rvIsaPkg::regIdx_t rd;
        rvIsaPkg::word_t   rdValue;
        logic              memWrite;
        rvIsaPkg::word_t   memAddr;
        rvIsaPkg::word_t   memData;
    } retire_t;

endpackage

`default_nettype wire

//--- verilog/rvSequencer.sv
`default_nettype none

module rvSequencer (
    input  logic              clk,
    input  logic              reset,
    output rvCorePkg::phase_t phase,
    output logic              retireStrobe,
    output rvIsaPkg::word_t   instrCount
);

    assign retireStrobe = (phase == rvCorePkg::WRITEBACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase      <= rvCorePkg::FETCH;
            instrCount <= '0;
        end else begin
            case (phase)
                rvCorePkg::FETCH:   phase <= rvCorePkg::DECODE;
                rvCorePkg::DECODE:  phase <= rvCorePkg::EXECUTE;
                rvCorePkg::EXECUTE: phase <= rvCorePkg::WRITEBACK;
                default:            phase <= rvCorePkg::FETCH;
            endcase
            if (retireStrobe) begin
                instrCount <= instrCount + 1'b1; // Counts at the retiring edge
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rvFetchStage.sv
`default_nettype none

`include "rv_settings.svh"

module rvFetchStage (
    input  logic                 clk,
    input  logic                 reset,
    input  rvCorePkg::phase_t    phase,
    input  logic                 loadEn,
    input  rvIsaPkg::word_t      loadAddr,
    input  rvIsaPkg::word_t      loadData,
    input  logic                 pcLoad,
    input  rvIsaPkg::word_t      nextPc,
    output rvCorePkg::fetchOut_t fetchOut
);

    localparam int IMEM_AW = $clog2(`RV_IMEM_DEPTH);

    rvIsaPkg::word_t imem [`RV_IMEM_DEPTH];
    rvIsaPkg::word_t pc;

    // Program load port, word indexed
    always_ff @(posedge clk) begin
        if (loadEn) begin
            imem[loadAddr[IMEM_AW-1:0]] <= loadData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (pcLoad) begin
            pc <= nextPc; // Redirect from writeback
        end
    end

    always_ff @(posedge clk) begin
        if (phase == rvCorePkg::FETCH) begin
            fetchOut.pc    <= pc;
            fetchOut.instr <= imem[pc[IMEM_AW+1:2]];
        end
    end

endmodule

`default_nettype wire

//--- verilog/rvDecodeStage.sv
`default_nettype none

module rvDecodeStage (
    input  logic                  clk,
    input  logic                  reset,
    input  rvCorePkg::phase_t     phase,
    input  rvCorePkg::fetchOut_t  fetchOut,
    input  rvIsaPkg::word_t       rs1Data,
    input  rvIsaPkg::word_t       rs2Data,
    output rvIsaPkg::regIdx_t     rs1Idx,
    output rvIsaPkg::regIdx_t     rs2Idx,
    output rvCorePkg::decodeOut_t decodeOut
);

    rvIsaPkg::word_t  instr;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    rvCorePkg::ctrl_t ctrl;
    rvIsaPkg::word_t  imm;

    // funct3 to ALU op for OP and OP_IMM
    function automatic rvIsaPkg::aluOp_t arithOp(input logic [2:0] f3, input logic alt);
        rvIsaPkg::aluOp_t op;
        case (f3)
            3'b000:  op = alt ? rvIsaPkg::SUB : rvIsaPkg::ADD;
            3'b001:  op = rvIsaPkg::SLL;
            3'b010:  op = rvIsaPkg::SLT;
            3'b011:  op = rvIsaPkg::SLTU;
            3'b100:  op = rvIsaPkg::XOR;
            3'b101:  op = alt ? rvIsaPkg::SRA : rvIsaPkg::SRL;
            3'b110:  op = rvIsaPkg::OR;
            default: op = rvIsaPkg::AND;
        endcase
        return op;
    endfunction

    function automatic rvIsaPkg::aluOp_t branchOp(input logic [2:0] f3);
        rvIsaPkg::aluOp_t op;
        case (f3)
            3'b001:  op = rvIsaPkg::NE;
            3'b100:  op = rvIsaPkg::LT;
            3'b101:  op = rvIsaPkg::GE;
            3'b110:  op = rvIsaPkg::LTU;
            3'b111:  op = rvIsaPkg::GEU;
            default: op = rvIsaPkg::EQ;
        endcase
        return op;
    endfunction

    assign instr  = fetchOut.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1Idx = instr[19:15];
    assign rs2Idx = instr[24:20];

    always_comb begin
        ctrl = '0; // Unknown opcodes stay inactive
        imm  = {{20{instr[31]}}, instr[31:20]};
        case (opcode)
            rvIsaPkg::OP: begin
                ctrl.aluOp    = arithOp(funct3, instr[30]);
                ctrl.regWrite = 1'b1;
            end
            rvIsaPkg::OP_IMM: begin
                ctrl.aluOp    = arithOp(funct3, instr[30] && funct3 == 3'b101);
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            rvIsaPkg::LOAD: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
            end
            rvIsaPkg::STORE: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
                imm           = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rvIsaPkg::BRANCH: begin
                ctrl.aluOp    = branchOp(funct3);
                ctrl.isBranch = 1'b1;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            rvIsaPkg::JAL: begin
                ctrl.usePc        = 1'b1; // Target is pc+imm through the ALU
                ctrl.useImm       = 1'b1;
                ctrl.regWrite     = 1'b1;
                ctrl.isJump       = 1'b1;
                ctrl.resultIsLink = 1'b1;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            rvIsaPkg::JALR: begin
                ctrl.useImm       = 1'b1;
                ctrl.regWrite     = 1'b1;
                ctrl.isJump       = 1'b1;
                ctrl.resultIsLink = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decodeOut.ctrl <= '0;
        end else if (phase == rvCorePkg::DECODE) begin
            decodeOut.pc     <= fetchOut.pc;
            decodeOut.ctrl   <= ctrl;
            decodeOut.rs1Val <= rs1Data;
            decodeOut.rs2Val <= rs2Data;
            decodeOut.imm    <= imm;
            decodeOut.rd     <= instr[11:7];
        end
    end

endmodule

`default_nettype wire

//--- verilog/rvRegFile.sv
`default_nettype none

module rvRegFile (
    input  logic              clk,
    input  logic              reset,
    input  rvIsaPkg::regIdx_t rs1Idx,
    input  rvIsaPkg::regIdx_t rs2Idx,
    input  logic              wrEn,
    input  rvIsaPkg::regIdx_t wrIdx,
    input  rvIsaPkg::word_t   wrData,
    output rvIsaPkg::word_t   rs1Data,
    output rvIsaPkg::word_t   rs2Data
);

    rvIsaPkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrIdx != '0) begin
            regs[wrIdx] <= wrData; // x0 writes dropped
        end
    end

    assign rs1Data = (rs1Idx == '0) ? '0 : regs[rs1Idx];
    assign rs2Data = (rs2Idx == '0) ? '0 : regs[rs2Idx];

endmodule

`default_nettype wire

//--- verilog/rvExecuteStage.sv
`default_nettype none

module rvExecuteStage (
    input  logic                  clk,
    input  logic                  reset,
    input  rvCorePkg::phase_t     phase,
    input  rvCorePkg::decodeOut_t decodeOut,
    output rvCorePkg::execOut_t   execOut
);

    rvIsaPkg::word_t opA;
    rvIsaPkg::word_t opB;
    logic [4:0]      shamt;
    rvIsaPkg::word_t aluResult;
    rvIsaPkg::word_t nextPc;

    assign opA   = decodeOut.ctrl.usePc ? decodeOut.pc : decodeOut.rs1Val;
    assign opB   = decodeOut.ctrl.useImm ? decodeOut.imm : decodeOut.rs2Val;
    assign shamt = opB[4:0];

    always_comb begin
        aluResult = '0;
        case (decodeOut.ctrl.aluOp)
            rvIsaPkg::ADD:  aluResult = opA + opB;
            rvIsaPkg::SUB:  aluResult = opA - opB;
            rvIsaPkg::AND:  aluResult = opA & opB;
            rvIsaPkg::OR:   aluResult = opA | opB;
            rvIsaPkg::XOR:  aluResult = opA ^ opB;
            rvIsaPkg::SLT,
            rvIsaPkg::LT:   aluResult = rvIsaPkg::word_t'($signed(opA) < $signed(opB));
            rvIsaPkg::SLTU,
            rvIsaPkg::LTU:  aluResult = rvIsaPkg::word_t'(opA < opB);
            rvIsaPkg::SLL:  aluResult = opA << shamt;
            rvIsaPkg::SRL:  aluResult = opA >> shamt;
            rvIsaPkg::SRA:  aluResult = $signed(opA) >>> shamt;
            rvIsaPkg::EQ:   aluResult = rvIsaPkg::word_t'(opA == opB);
            rvIsaPkg::NE:   aluResult = rvIsaPkg::word_t'(opA != opB);
            rvIsaPkg::GE:   aluResult = rvIsaPkg::word_t'($signed(opA) >= $signed(opB));
            rvIsaPkg::GEU:  aluResult = rvIsaPkg::word_t'(opA >= opB);
            default:        aluResult = '0;
        endcase
    end

    // Jumps take the ALU sum, low bit cleared for JALR
    always_comb begin
        if (decodeOut.ctrl.isJump) begin
            nextPc = aluResult & ~rvIsaPkg::word_t'(1);
        end else if (decodeOut.ctrl.isBranch && aluResult[0]) begin
            nextPc = decodeOut.pc + decodeOut.imm;
        end else begin
            nextPc = decodeOut.pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            execOut.ctrl <= '0;
        end else if (phase == rvCorePkg::EXECUTE) begin
            execOut.pc        <= decodeOut.pc;
            execOut.ctrl      <= decodeOut.ctrl;
            execOut.aluResult <= aluResult;
            execOut.storeData <= decodeOut.rs2Val;
            execOut.rd        <= decodeOut.rd;
            execOut.nextPc    <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rvMemWbStage.sv
`default_nettype none

`include "rv_settings.svh"

module rvMemWbStage (
    input  logic                clk,
    input  logic                reset,
    input  rvCorePkg::phase_t   phase,
    input  rvCorePkg::execOut_t execOut,
    input  logic                retireStrobe,
    output logic                pcLoad,
    output logic                regWrEn,
    output rvIsaPkg::word_t     nextPc,
    output rvIsaPkg::regIdx_t   regWrIdx,
    output rvIsaPkg::word_t     regWrData,
    output logic                retireValid,
    output rvCorePkg::retire_t  retire
);

    localparam int DMEM_AW = $clog2(`RV_DMEM_DEPTH);

    rvIsaPkg::word_t  dmem [`RV_DMEM_DEPTH];
    logic [DMEM_AW-1:0] dmemIdx;
    rvIsaPkg::word_t  loadData;
    logic             wbActive;
    logic             rdWritten;

    assign wbActive = (phase == rvCorePkg::WRITEBACK);
    assign dmemIdx  = execOut.aluResult[DMEM_AW+1:2]; // Word index wraps at depth
    assign loadData = dmem[dmemIdx];

    assign pcLoad    = wbActive;
    assign nextPc    = execOut.nextPc;
    assign regWrEn   = wbActive && execOut.ctrl.regWrite;
    assign regWrIdx  = execOut.rd;
    assign regWrData = execOut.ctrl.memRead      ? loadData :
                       execOut.ctrl.resultIsLink ? execOut.pc + 32'd4 :
                                                   execOut.aluResult;
    assign rdWritten = execOut.ctrl.regWrite && execOut.rd != '0;

    always_ff @(posedge clk) begin
        if (wbActive && execOut.ctrl.memWrite) begin
            dmem[dmemIdx] <= execOut.storeData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= retireStrobe;
        end
    end

    // Unused record fields read as zero
    always_ff @(posedge clk) begin
        if (retireStrobe) begin
            retire.pc       <= execOut.pc;
            retire.regWrite <= rdWritten;
            retire.rd       <= rdWritten ? execOut.rd : '0;
            retire.rdValue  <= rdWritten ? regWrData : '0;
            retire.memWrite <= execOut.ctrl.memWrite;
            retire.memAddr  <= execOut.ctrl.memWrite ? execOut.aluResult : '0;
            retire.memData  <= execOut.ctrl.memWrite ? execOut.storeData : '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rvCore.sv
`default_nettype none

module rvCore (
    input  logic               clk,
    input  logic               reset,
    input  logic               loadEn,
    input  rvIsaPkg::word_t    loadAddr,
    input  rvIsaPkg::word_t    loadData,
    output logic               retireValid,
    output rvCorePkg::retire_t retire,
    output rvIsaPkg::word_t    instrCount
);

    rvCorePkg::phase_t     phase;
    logic                  retireStrobe;
    rvCorePkg::fetchOut_t  fetchOut;
    rvCorePkg::decodeOut_t decodeOut;
    rvCorePkg::execOut_t   execOut;
    rvIsaPkg::regIdx_t     rs1Idx;
    rvIsaPkg::regIdx_t     rs2Idx;
    rvIsaPkg::word_t       rs1Data;
    rvIsaPkg::word_t       rs2Data;
    logic                  pcLoad;
    rvIsaPkg::word_t       nextPc;
    logic                  regWrEn;
    rvIsaPkg::regIdx_t     regWrIdx;
    rvIsaPkg::word_t       regWrData;

    rvSequencer u_seq (.clk, .reset, .phase, .retireStrobe, .instrCount);

    rvFetchStage u_fetch (.clk, .reset, .phase, .loadEn, .loadAddr, .loadData,
                          .pcLoad, .nextPc, .fetchOut);

    rvDecodeStage u_decode (.clk, .reset, .phase, .fetchOut, .rs1Data, .rs2Data,
                            .rs1Idx, .rs2Idx, .decodeOut);

    rvRegFile u_regs (.clk, .reset, .rs1Idx, .rs2Idx, .wrEn(regWrEn), .wrIdx(regWrIdx),
                      .wrData(regWrData), .rs1Data, .rs2Data);

    rvExecuteStage u_exec (.clk, .reset, .phase, .decodeOut, .execOut);

    rvMemWbStage u_memWb (.clk, .reset, .phase, .execOut, .retireStrobe, .pcLoad,
                          .regWrEn, .nextPc, .regWrIdx, .regWrData, .retireValid, .retire);

endmodule

`default_nettype wire

//--- verification/rvClockGen.sv
`default_nettype none

module rvClockGen #(
    parameter int PERIOD = 20
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- verification/rvCore_sva.sv
`default_nettype none

module rvCoreSva (
    input logic               clk,
    input logic               reset,
    input rvCorePkg::phase_t  phase,
    input logic               retireValid,
    input rvCorePkg::retire_t retire
);

    int         failCount = 0; // Read by the testbench
    logic [1:0] phaseCode;

    assign phaseCode = phase;

    // Wraps from writeback to fetch in two bits
    phaseOrder: assert property (@(posedge clk) disable iff (reset)
        1'b1 |=> phaseCode == $past(phaseCode) + 2'd1)
        else begin
            failCount = failCount + 1;
            $error("phase left the fetch, decode, execute, writeback order");
        end

    retireSingle: assert property (@(posedge clk) disable iff (reset)
        retireValid |=> !retireValid)
        else begin
            failCount = failCount + 1;
            $error("retireValid high on two consecutive cycles");
        end

    noX0Write: assert property (@(posedge clk) disable iff (reset)
        retireValid |-> !(retire.regWrite && retire.rd == 5'd0))
        else begin
            failCount = failCount + 1;
            $error("retire record shows a write to x0");
        end

endmodule

bind rvCore rvCoreSva u_sva (.clk(clk), .reset(reset), .phase(phase),
                             .retireValid(retireValid), .retire(retire));

`default_nettype wire

//--- verification/rvCoreTb.sv
`default_nettype none

`include "rv_settings.svh"

module rvCoreTb;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int PROG_LEN       = RESET_CYCLES; // One word loaded per reset cycle
    localparam int NUM_PROGS      = 20;
    localparam int RETIRES        = 48;           // Checked per program
    localparam int TIMEOUT_CYCLES = NUM_PROGS * (RETIRES * 4 + RESET_CYCLES + 4) + 200;

    logic               clk;
    logic               reset;
    logic               loadEn;
    rvIsaPkg::word_t    loadAddr;
    rvIsaPkg::word_t    loadData;
    logic               retireValid;
    rvCorePkg::retire_t retire;
    rvIsaPkg::word_t    instrCount;

    integer          seed = 32'h0d5a_d890;
    rvIsaPkg::word_t prog [PROG_LEN];
    rvIsaPkg::word_t regs [32];                 // ISA model state
    rvIsaPkg::word_t dmem [`RV_DMEM_DEPTH];     // Kept across programs like the DUT's
    rvIsaPkg::word_t modelPc;
    int              retireCount;
    int              sinceLast;

    rvClockGen #(.PERIOD(CLK_PERIOD)) u_clk (.clk);

    rvCore u_dut (.clk, .reset, .loadEn, .loadAddr, .loadData, .retireValid, .retire,
                  .instrCount);

    function automatic rvIsaPkg::word_t encR(input logic [6:0] f7, input rvIsaPkg::regIdx_t rs2,
                                             input rvIsaPkg::regIdx_t rs1, input logic [2:0] f3,
                                             input rvIsaPkg::regIdx_t rd);
        return {f7, rs2, rs1, f3, rd, rvIsaPkg::OP};
    endfunction

    function automatic rvIsaPkg::word_t encI(input rvIsaPkg::word_t imm,
                                             input rvIsaPkg::regIdx_t rs1, input logic [2:0] f3,
                                             input rvIsaPkg::regIdx_t rd, input logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic rvIsaPkg::word_t encS(input rvIsaPkg::word_t imm,
                                             input rvIsaPkg::regIdx_t rs2,
                                             input rvIsaPkg::regIdx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvIsaPkg::STORE};
    endfunction

    function automatic rvIsaPkg::word_t encB(input rvIsaPkg::word_t off,
                                             input rvIsaPkg::regIdx_t rs2,
                                             input rvIsaPkg::regIdx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvIsaPkg::BRANCH};
    endfunction

    function automatic rvIsaPkg::word_t encJ(input rvIsaPkg::word_t off,
                                             input rvIsaPkg::regIdx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, rvIsaPkg::JAL};
    endfunction

    // Random legal program with in-range targets, ending in a self loop
    task automatic genProgram(input int progIdx);
        rvIsaPkg::word_t   r;
        rvIsaPkg::word_t   imm;
        rvIsaPkg::word_t   memOff;
        rvIsaPkg::regIdx_t rd;
        rvIsaPkg::regIdx_t rs1;
        rvIsaPkg::regIdx_t rs2;
        logic [2:0]        f3;
        int                tgt;
        for (int i = 0; i < PROG_LEN - 1; i++) begin
            r      = $random(seed);
            tgt    = $unsigned($random(seed)) % PROG_LEN;
            tgt    = (tgt == i) ? i + 1 : tgt;
            rd     = {2'b00, r[2:0]}; // Few registers so results feed later ops
            rs1    = {2'b00, r[5:3]};
            rs2    = {2'b00, r[8:6]};
            f3     = r[11:9];
            memOff = {28'd0, r[31:30], 2'b00};
            case (r[14:12])
                3'd0, 3'd1: begin
                    prog[i] = encR(((f3 == 3'd0 || f3 == 3'd5) && r[15]) ? 7'h20 : 7'h00,
                                   rs2, rs1, f3, rd);
                end
                3'd2, 3'd3: begin
                    if (f3 == 3'd1) begin
                        imm = {27'd0, r[20:16]};
                    end else if (f3 == 3'd5) begin
                        imm = {21'd0, r[15], 5'd0, r[20:16]}; // SRLI or SRAI
                    end else begin
                        imm = {20'd0, r[27:16]};
                    end
                    prog[i] = encI(imm, rs1, f3, rd, rvIsaPkg::OP_IMM);
                end
                3'd4: prog[i] = encI(memOff, 5'd0, 3'b010, rd, rvIsaPkg::LOAD);
                3'd5: prog[i] = encS(memOff, rs2, 5'd0);
                3'd6: begin
                    if (f3 == 3'd2 || f3 == 3'd3) begin
                        f3 = f3 ^ 3'b110; // Onto BLT or BGE
                    end
                    prog[i] = encB((tgt - i) * 4, rs2, rs1, f3);
                end
                default: begin
                    case (r[29:28])
                        2'd0:    prog[i] = encJ((tgt - i) * 4, rd);
                        2'd1:    prog[i] = encI(tgt * 4, 5'd0, 3'b000, rd, rvIsaPkg::JALR);
                        default: prog[i] = {r[31:7], r[28] ? 7'h37 : 7'h73}; // Unsupported
                    endcase
                end
            endcase
        end
        prog[PROG_LEN-1] = encJ('0, 5'd0);
        if (progIdx == 0) begin
            for (int k = 0; k < 4; k++) begin
                prog[k] = encS(k * 4, 5'd0, 5'd0); // Defines the words loads read
            end
        end
    endtask

    function automatic rvIsaPkg::word_t aluRef(input logic [2:0] f3, input logic alt,
                                               input rvIsaPkg::word_t x, input rvIsaPkg::word_t y);
        case (f3)
            3'd0:    return alt ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3:    return (x < y) ? 32'd1 : 32'd0;
            3'd4:    return x ^ y;
            3'd5:    return alt ? rvIsaPkg::word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input rvIsaPkg::word_t x,
                                         input rvIsaPkg::word_t y);
        case (f3)
            3'd0:    return x == y;
            3'd1:    return x != y;
            3'd4:    return $signed(x) < $signed(y);
            3'd5:    return $signed(x) >= $signed(y);
            3'd6:    return x < y;
            3'd7:    return x >= y;
            default: return 1'b0;
        endcase
    endfunction

    // Executes the instruction at modelPc and returns what should retire
    function automatic rvCorePkg::retire_t stepModel();
        rvCorePkg::retire_t r;
        rvIsaPkg::word_t    ins;
        rvIsaPkg::word_t    a;
        rvIsaPkg::word_t    b;
        rvIsaPkg::word_t    immI;
        rvIsaPkg::word_t    immS;
        rvIsaPkg::word_t    res;
        rvIsaPkg::word_t    nextPc;
        logic               wr;
        ins    = prog[(modelPc >> 2) % PROG_LEN];
        a      = regs[ins[19:15]];
        b      = regs[ins[24:20]];
        immI   = {{20{ins[31]}}, ins[31:20]};
        immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        r      = '0;
        r.pc   = modelPc;
        wr     = 1'b0;
        res    = '0;
        nextPc = modelPc + 32'd4;
        case (ins[6:0])
            rvIsaPkg::OP: begin
                wr  = 1'b1;
                res = aluRef(ins[14:12], ins[30], a, b);
            end
            rvIsaPkg::OP_IMM: begin
                wr  = 1'b1;
                res = aluRef(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, immI);
            end
            rvIsaPkg::LOAD: begin
                wr  = 1'b1;
                res = dmem[((a + immI) >> 2) % `RV_DMEM_DEPTH];
            end
            rvIsaPkg::STORE: begin
                r.memWrite = 1'b1;
                r.memAddr  = a + immS;
                r.memData  = b;
                dmem[((a + immS) >> 2) % `RV_DMEM_DEPTH] = b;
            end
            rvIsaPkg::BRANCH: begin
                if (branchTaken(ins[14:12], a, b)) begin
                    nextPc = modelPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            rvIsaPkg::JAL: begin
                wr     = 1'b1;
                res    = modelPc + 32'd4;
                nextPc = modelPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            rvIsaPkg::JALR: begin
                wr     = 1'b1;
                res    = modelPc + 32'd4;
                nextPc = (a + immI) & ~32'd1;
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            regs[ins[11:7]] = res;
            r.regWrite      = 1'b1;
            r.rd            = ins[11:7];
            r.rdValue       = res;
        end
        modelPc = nextPc;
        return r;
    endfunction

    task automatic stopRun();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic checkRetire(input rvCorePkg::retire_t got, input rvCorePkg::retire_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t retire got %h expected %h", $time, got, exp);
            $display("  pc %h/%h rd %0d/%0d rdValue %h/%h memAddr %h/%h memData %h/%h",
                     got.pc, exp.pc, got.rd, exp.rd, got.rdValue, exp.rdValue,
                     got.memAddr, exp.memAddr, got.memData, exp.memData);
            stopRun();
        end
    endtask

    task automatic checkCount(input rvIsaPkg::word_t got, input rvIsaPkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t instrCount got %0d expected %0d", $time, got, exp);
            stopRun();
        end
    endtask

    // Outputs change on rising edges, sampled here on falling ones
    always @(negedge clk) begin
        if (reset) begin
            sinceLast = 0;
        end else begin
            sinceLast = sinceLast + 1;
            if (u_dut.u_sva.failCount != 0) begin
                $display("An assertion on the core failed before t=%0t", $time);
                stopRun();
            end
            if (retireValid) begin
                if (sinceLast != 4) begin
                    $display("Retire at t=%0t came %0d cycles after the last one, not 4",
                             $time, sinceLast);
                    stopRun();
                end
                checkRetire(retire, stepModel());
                retireCount = retireCount + 1;
                checkCount(instrCount, rvIsaPkg::word_t'(retireCount));
                sinceLast = 0;
            end
        end
    end

    initial begin : mainFlow
        reset       = 1'b1;
        loadEn      = 1'b0;
        loadAddr    = '0;
        loadData    = '0;
        retireCount = 0;
        sinceLast   = 0;
        modelPc     = '0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            genProgram(p);
            @(negedge clk);
            reset       <= 1'b1;
            retireCount = 0;
            modelPc     = '0;
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            for (int i = 0; i < PROG_LEN; i++) begin
                loadEn   <= 1'b1;
                loadAddr <= i;
                loadData <= prog[i];
                @(negedge clk);
            end
            loadEn <= 1'b0;
            reset  <= 1'b0;
            wait (retireCount == RETIRES);
        end
        $display("PASS: all tests");
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired at t=%0t, retirement stalled after %0d retires",
                 $time, retireCount);
        stopRun();
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/rvIsaPkg.sv
verilog/rvCorePkg.sv
verilog/rvSequencer.sv
verilog/rvFetchStage.sv
verilog/rvDecodeStage.sv
verilog/rvRegFile.sv
verilog/rvExecuteStage.sv
verilog/rvMemWbStage.sv
verilog/rvCore.sv
verification/rvClockGen.sv
verification/rvCore_sva.sv
verification/rvCoreTb.sv
